// File: src/periph_pkg.sv
/*
 * Peripheral package
 * Bus widths, page-0 device codes and the interrupt controller data views
 */
package periph_pkg;

    localparam int DATA_W = 8;
    localparam int ADDR_W = 10;

    // Address bits 7..5 of a page-0 I/O cycle
    localparam logic [2:0] DEV_PIC = 3'd1;
    localparam logic [2:0] DEV_PPI = 3'd3;

    localparam int IRQ_N   = 8;
    localparam int IRQ_KBD = 1;

    // Stored without the level bits, 0x08 on the bus
    localparam logic [4:0] VEC_BASE_RST = 5'h01;

    // Command byte bits at 0x20
    localparam int EOI_BIT  = 5;
    localparam int INIT_BIT = 4;

    // Data byte at 0x21 right after an INIT command
    typedef struct packed {
        logic [4:0] vec_base;
        logic [2:0] reserved;
    } pic_init_t;

    // Same byte seen as a plain mask or as init data
    typedef union packed {
        logic [DATA_W-1:0] mask;
        pic_init_t         init;
    } pic_data_u;

endpackage

// File: src/io_bus_if.sv
/*
 * Internal I/O bus
 * Decoded selects, write strobe and per-device read data
 */
`timescale 1ns/1ps

interface io_bus_if;
    import periph_pkg::*;

    logic              pic_sel;
    logic              ppi_sel;
    logic              wr_stb;
    logic [1:0]        reg_addr;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] pic_rdata;
    logic [DATA_W-1:0] vector;
    logic              int_req;
    logic [DATA_W-1:0] ppi_rdata;

    modport bus (output pic_sel, ppi_sel, wr_stb, reg_addr, wdata,
                 input  pic_rdata, vector, ppi_rdata);
    modport pic (input  pic_sel, wr_stb, reg_addr, wdata,
                 output pic_rdata, vector, int_req);
    modport ppi (input  ppi_sel, wr_stb, reg_addr, wdata,
                 output ppi_rdata);

endinterface

// File: src/isa_bus_interface.sv
/*
 * ISA bus front end
 * Decodes page-0 I/O cycles into device selects and strobes,
 * and merges device read data onto the CPU data bus
 */
`timescale 1ns/1ps

module isa_bus_interface (
    input  logic                          clock,
    input  logic                          reset,
    input  logic [periph_pkg::ADDR_W-1:0] address_i,
    input  logic [periph_pkg::DATA_W-1:0] data_i,
    input  logic                          io_read_n_i,
    input  logic                          io_write_n_i,
    input  logic                          address_enable_n_i,
    input  logic                          interrupt_acknowledge_n_i,
    io_bus_if.bus                         bus,
    output logic [periph_pkg::DATA_W-1:0] data_bus_out_o,
    output logic                          data_bus_out_from_chipset_o,
    output logic                          ack_stb_o
);
    import periph_pkg::*;

    logic page0;
    logic io_read;
    logic prev_write_n;
    logic prev_ack_n;

    // Chipset owns page 0 only while AEN is low
    assign page0 = ~address_enable_n_i & (address_i[ADDR_W-1:ADDR_W-2] == 2'b00);

    assign bus.pic_sel  = page0 & (address_i[7:5] == DEV_PIC);
    assign bus.ppi_sel  = page0 & (address_i[7:5] == DEV_PPI);
    assign bus.reg_addr = address_i[1:0];
    assign bus.wdata    = data_i;

    // Previous samples of the strobe lines
    always_ff @(posedge clock) begin
        if (reset) begin
            prev_write_n <= 1'b1;
            prev_ack_n   <= 1'b1;
        end else begin
            prev_write_n <= io_write_n_i;
            prev_ack_n   <= interrupt_acknowledge_n_i;
        end
    end

    // One cycle on the falling edge of each strobe
    assign bus.wr_stb = ~io_write_n_i & prev_write_n;
    assign ack_stb_o  = ~interrupt_acknowledge_n_i & prev_ack_n;

    assign io_read = ~io_read_n_i;

    // Read merge, acknowledge first
    always_comb begin
        data_bus_out_o              = '0;
        data_bus_out_from_chipset_o = 1'b0;
        if (~interrupt_acknowledge_n_i) begin
            data_bus_out_o              = bus.vector;
            data_bus_out_from_chipset_o = 1'b1;
        end else if (bus.pic_sel && io_read) begin
            data_bus_out_o              = bus.pic_rdata;
            data_bus_out_from_chipset_o = 1'b1;
        end else if (bus.ppi_sel && io_read) begin
            data_bus_out_o              = bus.ppi_rdata;
            data_bus_out_from_chipset_o = 1'b1;
        end
    end

    sel_exclusive_a: assert property (
        @(posedge clock) disable iff (reset)
        !(bus.pic_sel && bus.ppi_sel)
    );

endmodule

// File: src/ps2_receiver.sv
/*
 * PS/2 receiver
 * Synchronizes the keyboard lines and turns checked 11-bit frames into bytes
 */
`timescale 1ns/1ps

module ps2_receiver #(
    parameter int PS2_TIMEOUT = 1000
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          ps2_clock_i,
    input  logic                          ps2_data_i,
    output logic [periph_pkg::DATA_W-1:0] byte_o,
    output logic                          byte_valid_o
);
    localparam int CNT_W = $clog2(PS2_TIMEOUT + 1);

    logic             clk_s1;
    logic             clk_s2;
    logic             clk_prev;
    logic             data_s1;
    logic             data_s2;
    logic             clk_fall;
    logic [10:0]      frame;
    logic [3:0]       bit_cnt;
    logic             frame_done;
    logic [CNT_W-1:0] idle_cnt;
    logic             frame_ok;

    // Two-flop synchronizers, lines idle high
    always_ff @(posedge clock) begin
        if (reset) begin
            clk_s1   <= 1'b1;
            clk_s2   <= 1'b1;
            clk_prev <= 1'b1;
            data_s1  <= 1'b1;
            data_s2  <= 1'b1;
        end else begin
            clk_s1   <= ps2_clock_i;
            clk_s2   <= clk_s1;
            clk_prev <= clk_s2;
            data_s1  <= ps2_data_i;
            data_s2  <= data_s1;
        end
    end

    assign clk_fall = clk_prev & ~clk_s2;

    // Bits arrive LSB first, so shift in from the top
    always_ff @(posedge clock) begin
        if (clk_fall) begin
            frame <= {data_s2, frame[10:1]};
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            bit_cnt    <= '0;
            frame_done <= 1'b0;
            idle_cnt   <= '0;
        end else begin
            frame_done <= 1'b0;
            if (clk_fall) begin
                idle_cnt <= '0;
                if (bit_cnt == 4'd10) begin
                    bit_cnt    <= '0;
                    frame_done <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (bit_cnt != 4'd0) begin
                // Stalled mid-frame, drop the partial frame
                if (idle_cnt == CNT_W'(PS2_TIMEOUT - 1)) begin
                    bit_cnt  <= '0;
                    idle_cnt <= '0;
                end else begin
                    idle_cnt <= idle_cnt + 1'b1;
                end
            end
        end
    end

    // Start low, stop high, odd parity over data and parity bit
    assign frame_ok = ~frame[0] & frame[10] & (^frame[9:1]);

    always_ff @(posedge clock) begin
        if (reset) begin
            byte_valid_o <= 1'b0;
        end else begin
            byte_valid_o <= frame_done & frame_ok;
        end
    end

    always_ff @(posedge clock) begin
        if (frame_done) begin
            byte_o <= frame[8:1];
        end
    end

    bit_cnt_range_a: assert property (
        @(posedge clock) disable iff (reset)
        bit_cnt < 4'd11
    );

endmodule

// File: src/keyboard_port.sv
/*
 * PPI-style keyboard port
 * Scancode latch on port A, control register on port B, inputs on port C
 */
`timescale 1ns/1ps

module keyboard_port (
    input  logic                          clock,
    input  logic                          reset,
    input  logic [periph_pkg::DATA_W-1:0] byte_i,
    input  logic                          byte_valid_i,
    input  logic [periph_pkg::DATA_W-1:0] port_c_i,
    io_bus_if.ppi                         bus,
    output logic [periph_pkg::DATA_W-1:0] port_b_o,
    output logic                          kbd_irq_o,
    output logic                          ps2_clock_o
);
    import periph_pkg::*;

    logic [DATA_W-1:0] scancode;
    logic [DATA_W-1:0] port_b;
    logic              key_held;
    logic              clear_key;
    logic              port_b_wr;

    // Port B bit 7 acknowledges the key
    assign clear_key = port_b[7];
    assign port_b_wr = bus.wr_stb & bus.ppi_sel & (bus.reg_addr == 2'd1);

    always_ff @(posedge clock) begin
        if (reset) begin
            port_b <= '0;
        end else if (port_b_wr) begin
            port_b <= bus.wdata;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            scancode <= '0;
            key_held <= 1'b0;
        end else if (clear_key) begin
            scancode <= '0;
            key_held <= 1'b0;
        end else if (byte_valid_i && !key_held) begin
            // A byte arriving while a key is held is lost
            scancode <= byte_i;
            key_held <= 1'b1;
        end
    end

    assign kbd_irq_o = key_held;
    assign port_b_o  = port_b;

    // Keyboard clock is released only when enabled and the latch is empty
    assign ps2_clock_o = port_b[6] & ~key_held;

    always_comb begin
        case (bus.reg_addr)
            2'd0:    bus.ppi_rdata = scancode;
            2'd1:    bus.ppi_rdata = port_b;
            2'd2:    bus.ppi_rdata = port_c_i;
            default: bus.ppi_rdata = '0;
        endcase
    end

endmodule

// File: src/interrupt_controller.sv
/*
 * Interrupt controller, 8259 style
 * Edge-triggered requests, mask, fixed priority with level 0 highest,
 * vector on acknowledge and non-specific end-of-interrupt
 */
`timescale 1ns/1ps

module interrupt_controller (
    input  logic                         clock,
    input  logic                         reset,
    input  logic [periph_pkg::IRQ_N-1:0] irq_i,
    input  logic                         ack_stb_i,
    io_bus_if.pic                        bus
);
    import periph_pkg::*;

    localparam int LVL_W = $clog2(IRQ_N);

    logic [IRQ_N-1:0]  req_q;
    logic [IRQ_N-1:0]  req_prev;
    logic [IRQ_N-1:0]  rise;
    logic [IRQ_N-1:0]  irr;
    logic [IRQ_N-1:0]  isr;
    logic [IRQ_N-1:0]  mask;
    logic [IRQ_N-1:0]  pending;
    logic [4:0]        vec_base;
    logic              init_pending;
    pic_data_u         wr_data;
    logic              cmd_wr;
    logic              data_wr;
    logic [LVL_W-1:0]  pend_top;
    logic [LVL_W-1:0]  isr_top;
    logic              do_ack;
    logic              do_eoi;
    logic [IRQ_N-1:0]  ack_set;
    logic [IRQ_N-1:0]  eoi_clr;
    logic [DATA_W-1:0] vector_live;
    logic [DATA_W-1:0] vector_hold;

    // Lowest set index wins
    function automatic logic [LVL_W-1:0] top_level(input logic [IRQ_N-1:0] bits);
        logic [LVL_W-1:0] lvl;
        lvl = '0;
        for (int i = IRQ_N - 1; i >= 0; i--) begin
            if (bits[i]) begin
                lvl = LVL_W'(i);
            end
        end
        return lvl;
    endfunction

    assign wr_data = bus.wdata;
    assign cmd_wr  = bus.wr_stb & bus.pic_sel & ~bus.reg_addr[0];
    assign data_wr = bus.wr_stb & bus.pic_sel & bus.reg_addr[0];

    assign rise     = req_q & ~req_prev;
    assign pending  = irr & ~mask;
    assign pend_top = top_level(pending);
    assign isr_top  = top_level(isr);

    // Request only beats the service in progress if it is higher priority
    assign bus.int_req = (|pending) & (~(|isr) | (pend_top < isr_top));

    assign do_ack  = ack_stb_i & bus.int_req;
    assign do_eoi  = cmd_wr & wr_data.mask[EOI_BIT] & (|isr);
    assign ack_set = do_ack ? (IRQ_N'(1) << pend_top) : '0;
    assign eoi_clr = do_eoi ? (IRQ_N'(1) << isr_top) : '0;

    always_ff @(posedge clock) begin
        if (reset) begin
            req_q    <= '0;
            req_prev <= '0;
            irr      <= '0;
            isr      <= '0;
        end else begin
            req_q    <= irq_i;
            req_prev <= req_q;
            irr      <= (irr & ~ack_set) | rise;
            isr      <= (isr | ack_set) & ~eoi_clr;
        end
    end

    // INIT arms the next data write as the vector base
    always_ff @(posedge clock) begin
        if (reset) begin
            mask         <= '1;
            vec_base     <= VEC_BASE_RST;
            init_pending <= 1'b0;
        end else if (data_wr) begin
            if (init_pending) begin
                vec_base     <= wr_data.init.vec_base;
                init_pending <= 1'b0;
            end else begin
                mask <= wr_data.mask;
            end
        end else if (cmd_wr && wr_data.mask[INIT_BIT]) begin
            init_pending <= 1'b1;
        end
    end

    assign vector_live = {vec_base, pend_top};

    // Keeps the acknowledged vector on the bus after the request drops
    always_ff @(posedge clock) begin
        if (reset) begin
            vector_hold <= {VEC_BASE_RST, 3'b000};
        end else if (bus.int_req) begin
            vector_hold <= vector_live;
        end
    end

    assign bus.vector    = bus.int_req ? vector_live : vector_hold;
    assign bus.pic_rdata = bus.reg_addr[0] ? mask : irr;

    isr_single_a: assert property (
        @(posedge clock) disable iff (reset)
        $onehot0(isr)
    );

    no_req_when_masked_a: assert property (
        @(posedge clock) disable iff (reset)
        !(|(irr & ~mask)) |-> !bus.int_req
    );

endmodule

// File: src/periph_top.sv
/*
 * XT peripheral slice
 * I/O decode, interrupt controller and PS/2 keyboard port on one CPU bus
 */
`timescale 1ns/1ps

module periph_top #(
    parameter int PS2_TIMEOUT = 1000
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic [periph_pkg::ADDR_W-1:0] address_i,
    input  logic [periph_pkg::DATA_W-1:0] data_i,
    input  logic                          io_read_n_i,
    input  logic                          io_write_n_i,
    input  logic                          address_enable_n_i,
    input  logic                          interrupt_acknowledge_n_i,
    input  logic [periph_pkg::IRQ_N-1:0]  interrupt_request_i,
    input  logic [periph_pkg::DATA_W-1:0] port_c_i,
    input  logic                          ps2_clock_i,
    input  logic                          ps2_data_i,
    output logic [periph_pkg::DATA_W-1:0] data_bus_out_o,
    output logic                          data_bus_out_from_chipset_o,
    output logic                          interrupt_to_cpu_o,
    output logic [periph_pkg::DATA_W-1:0] port_b_o,
    output logic                          ps2_clock_o
);
    import periph_pkg::*;

    logic              ack_stb;
    logic [DATA_W-1:0] kbd_byte;
    logic              kbd_byte_valid;
    logic              kbd_irq;
    logic [IRQ_N-1:0]  irq_lines;

    io_bus_if io_bus ();

    isa_bus_interface u_isa_bus_interface (
        .clock                       (clock),
        .reset                       (reset),
        .address_i                   (address_i),
        .data_i                      (data_i),
        .io_read_n_i                 (io_read_n_i),
        .io_write_n_i                (io_write_n_i),
        .address_enable_n_i          (address_enable_n_i),
        .interrupt_acknowledge_n_i   (interrupt_acknowledge_n_i),
        .bus                         (io_bus.bus),
        .data_bus_out_o              (data_bus_out_o),
        .data_bus_out_from_chipset_o (data_bus_out_from_chipset_o),
        .ack_stb_o                   (ack_stb)
    );

    ps2_receiver #(
        .PS2_TIMEOUT (PS2_TIMEOUT)
    ) u_ps2_receiver (
        .clock        (clock),
        .reset        (reset),
        .ps2_clock_i  (ps2_clock_i),
        .ps2_data_i   (ps2_data_i),
        .byte_o       (kbd_byte),
        .byte_valid_o (kbd_byte_valid)
    );

    keyboard_port u_keyboard_port (
        .clock        (clock),
        .reset        (reset),
        .byte_i       (kbd_byte),
        .byte_valid_i (kbd_byte_valid),
        .port_c_i     (port_c_i),
        .bus          (io_bus.ppi),
        .port_b_o     (port_b_o),
        .kbd_irq_o    (kbd_irq),
        .ps2_clock_o  (ps2_clock_o)
    );

    // Keyboard takes over its request line
    assign irq_lines = (interrupt_request_i & ~(IRQ_N'(1) << IRQ_KBD))
                     | (IRQ_N'(kbd_irq) << IRQ_KBD);

    interrupt_controller u_interrupt_controller (
        .clock     (clock),
        .reset     (reset),
        .irq_i     (irq_lines),
        .ack_stb_i (ack_stb),
        .bus       (io_bus.pic)
    );

    assign interrupt_to_cpu_o = io_bus.int_req;

endmodule

// File: testbench/tb_periph.sv
/*
 * Testbench for the XT peripheral slice
 * Directed tests over bus access, PS/2 keyboard and the interrupt controller
 */
`timescale 1ns/1ps

module tb_periph;
    import periph_pkg::*;

    localparam int CLK_NS       = 8;
    localparam int PS2_HALF     = 5;
    localparam int WAIT_CYCLES  = 20;
    localparam int FRAME_CYCLES = 22 * PS2_HALF + 8;
    // Five frames, about seventy bus cycles, every timed wait, plus margin
    localparam int WATCHDOG_NS  =
        CLK_NS * (5 * FRAME_CYCLES + 70 * 3 + 12 * WAIT_CYCLES + 500);

    logic              clock;
    logic              reset;
    logic [ADDR_W-1:0] address;
    logic [DATA_W-1:0] data;
    logic              io_read_n;
    logic              io_write_n;
    logic              address_enable_n;
    logic              iack_n;
    logic [IRQ_N-1:0]  irq;
    logic [DATA_W-1:0] port_c;
    logic              ps2_clock;
    logic              ps2_data;
    logic [DATA_W-1:0] data_bus_out;
    logic              from_chipset;
    logic              cpu_int;
    logic [DATA_W-1:0] port_b;
    logic              kbd_clock_en;

    integer seed         = 42;
    int     err_count    = 0;
    int     tests_run    = 0;
    int     tests_failed = 0;

    periph_top #(
        .PS2_TIMEOUT (1000)
    ) dut (
        .clock                       (clock),
        .reset                       (reset),
        .address_i                   (address),
        .data_i                      (data),
        .io_read_n_i                 (io_read_n),
        .io_write_n_i                (io_write_n),
        .address_enable_n_i          (address_enable_n),
        .interrupt_acknowledge_n_i   (iack_n),
        .interrupt_request_i         (irq),
        .port_c_i                    (port_c),
        .ps2_clock_i                 (ps2_clock),
        .ps2_data_i                  (ps2_data),
        .data_bus_out_o              (data_bus_out),
        .data_bus_out_from_chipset_o (from_chipset),
        .interrupt_to_cpu_o          (cpu_int),
        .port_b_o                    (port_b),
        .ps2_clock_o                 (kbd_clock_en)
    );

    initial clock = 1'b0;
    always #(CLK_NS / 2) clock = ~clock;

    task automatic check(input string name, input logic [DATA_W-1:0] actual,
                         input logic [DATA_W-1:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s expected 0x%02h, got 0x%02h",
                     $time, name, expected, actual);
            err_count++;
        end
    endtask

    task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] value);
        @(negedge clock);
        address          = addr;
        data             = value;
        address_enable_n = 1'b0;
        io_write_n       = 1'b0;
        // Strobe edge falls in between
        @(negedge clock);
        io_write_n       = 1'b1;
        address_enable_n = 1'b1;
    endtask

    task automatic bus_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] value,
                            output logic chipset);
        @(negedge clock);
        address          = addr;
        address_enable_n = 1'b0;
        io_read_n        = 1'b0;
        @(negedge clock);
        value            = data_bus_out;
        chipset          = from_chipset;
        io_read_n        = 1'b1;
        address_enable_n = 1'b1;
    endtask

    task automatic read_expect(input logic [ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] expected);
        logic [DATA_W-1:0] value;
        logic              chipset;
        string             name;
        name = $sformatf("data_bus_out_o at 0x%03h", addr);
        bus_read(addr, value, chipset);
        check(name, value, expected);
        check("data_bus_out_from_chipset_o", chipset, 1'b1);
    endtask

    task automatic acknowledge(output logic [DATA_W-1:0] vec, output logic chipset);
        @(negedge clock);
        iack_n  = 1'b0;
        // Sampled after the acknowledge edge, when the held vector drives the bus
        @(negedge clock);
        vec     = data_bus_out;
        chipset = from_chipset;
        iack_n  = 1'b1;
    endtask

    task automatic ack_expect(input logic [DATA_W-1:0] expected);
        logic [DATA_W-1:0] vec;
        logic              chipset;
        acknowledge(vec, chipset);
        check("data_bus_out_o on acknowledge", vec, expected);
        check("data_bus_out_from_chipset_o on acknowledge", chipset, 1'b1);
        check("interrupt_to_cpu_o after acknowledge", cpu_int, 1'b0);
    endtask

    task automatic send_ps2_frame(input logic [7:0] value, input logic bad_parity);
        logic [10:0] bits;
        // Stop, odd parity, data LSB first, start
        bits = {1'b1, ~(^value) ^ bad_parity, value, 1'b0};
        @(negedge clock);
        for (int i = 0; i < 11; i++) begin
            ps2_data = bits[i];
            repeat (PS2_HALF) @(negedge clock);
            ps2_clock = 1'b0;
            repeat (PS2_HALF) @(negedge clock);
            ps2_clock = 1'b1;
        end
        ps2_data = 1'b1;
    endtask

    task automatic wait_irq(input logic level);
        int n;
        n = 0;
        while (cpu_int !== level && n < WAIT_CYCLES) begin
            @(negedge clock);
            n++;
        end
        if (cpu_int !== level) begin
            $display("Timed out at %0t ns waiting for interrupt_to_cpu_o to become %0b",
                     $time, level);
            err_count++;
        end
    endtask

    task automatic wait_key_latched();
        int n;
        n = 0;
        while (kbd_clock_en !== 1'b0 && n < WAIT_CYCLES) begin
            @(negedge clock);
            n++;
        end
        if (kbd_clock_en !== 1'b0) begin
            $display("Timed out at %0t ns: no scancode latched, ps2_clock_o stayed high",
                     $time);
            err_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (err_count == errs_before) begin
            $display("%-16s ok", name);
        end else begin
            tests_failed++;
            $display("%-16s failed with %0d errors", name, err_count - errs_before);
        end
    endtask

    task automatic test_reset();
        int                errs_before;
        logic [DATA_W-1:0] value;
        logic              chipset;
        errs_before = err_count;
        check("interrupt_to_cpu_o", cpu_int, 1'b0);
        check("ps2_clock_o", kbd_clock_en, 1'b0);
        check("port_b_o", port_b, 8'h00);
        check("data_bus_out_from_chipset_o", from_chipset, 1'b0);
        read_expect(10'h021, 8'hFF);
        // Unmapped device code
        bus_read(10'h080, value, chipset);
        check("data_bus_out_from_chipset_o at 0x080", chipset, 1'b0);
        report_test("reset", errs_before);
    endtask

    task automatic test_registers();
        int errs_before;
        errs_before = err_count;
        bus_write(10'h061, 8'h40);
        read_expect(10'h061, 8'h40);
        check("port_b_o", port_b, 8'h40);
        check("ps2_clock_o", kbd_clock_en, 1'b1);
        port_c = $random(seed);
        read_expect(10'h062, port_c);
        bus_write(10'h021, 8'h5A);
        read_expect(10'h021, 8'h5A);
        report_test("registers", errs_before);
    endtask

    task automatic test_keyboard();
        int         errs_before;
        logic [7:0] scan1;
        logic [7:0] scan2;
        errs_before = err_count;
        scan1 = $random(seed);
        scan2 = $random(seed);
        if (scan2 == scan1) begin
            scan2 = ~scan1;
        end
        send_ps2_frame(scan1, 1'b0);
        wait_key_latched();
        read_expect(10'h060, scan1);
        // Key still held, second byte is lost
        send_ps2_frame(scan2, 1'b0);
        repeat (8) @(negedge clock);
        read_expect(10'h060, scan1);
        bus_write(10'h061, 8'hC0);
        bus_write(10'h061, 8'h40);
        read_expect(10'h060, 8'h00);
        check("ps2_clock_o", kbd_clock_en, 1'b1);
        send_ps2_frame(scan2, 1'b1);
        repeat (8) @(negedge clock);
        read_expect(10'h060, 8'h00);
        check("ps2_clock_o", kbd_clock_en, 1'b1);
        send_ps2_frame(scan2, 1'b0);
        wait_key_latched();
        read_expect(10'h060, scan2);
        // Empty the latch and service level 1 with the reset base 0x08
        bus_write(10'h061, 8'hC0);
        bus_write(10'h061, 8'h40);
        bus_write(10'h021, 8'hFD);
        wait_irq(1'b1);
        ack_expect(8'h09);
        bus_write(10'h020, 8'h20);
        bus_write(10'h021, 8'hFF);
        report_test("keyboard", errs_before);
    endtask

    task automatic test_vector_eoi();
        int errs_before;
        errs_before = err_count;
        // INIT, then base byte 0x08 seen as init.vec_base = 1
        bus_write(10'h020, 8'h10);
        bus_write(10'h021, 8'h08);
        read_expect(10'h021, 8'hFF);
        bus_write(10'h021, 8'h00);
        check("interrupt_to_cpu_o", cpu_int, 1'b0);
        irq[3] = 1'b1;
        wait_irq(1'b1);
        ack_expect(8'h0B);
        // Level 4 waits behind level 3 in service
        irq[4] = 1'b1;
        repeat (4) @(negedge clock);
        check("interrupt_to_cpu_o during service", cpu_int, 1'b0);
        bus_write(10'h020, 8'h20);
        wait_irq(1'b1);
        ack_expect(8'h0C);
        bus_write(10'h020, 8'h20);
        irq[3] = 1'b0;
        irq[4] = 1'b0;
        report_test("vector and EOI", errs_before);
    endtask

    task automatic test_priority();
        int         errs_before;
        logic [7:0] scan;
        errs_before = err_count;
        scan = $random(seed);
        irq[5] = 1'b1;
        wait_irq(1'b1);
        send_ps2_frame(scan, 1'b0);
        wait_key_latched();
        repeat (2) @(negedge clock);
        read_expect(10'h020, 8'h22);
        ack_expect(8'h09);
        repeat (4) @(negedge clock);
        check("interrupt_to_cpu_o before EOI", cpu_int, 1'b0);
        bus_write(10'h020, 8'h20);
        wait_irq(1'b1);
        ack_expect(8'h0D);
        bus_write(10'h020, 8'h20);
        irq[5] = 1'b0;
        report_test("priority", errs_before);
    endtask

    task automatic test_masking();
        int errs_before;
        errs_before = err_count;
        bus_write(10'h021, 8'h40);
        irq[6] = 1'b1;
        repeat (4) @(negedge clock);
        check("interrupt_to_cpu_o while masked", cpu_int, 1'b0);
        read_expect(10'h020, 8'h40);
        bus_write(10'h021, 8'h00);
        wait_irq(1'b1);
        ack_expect(8'h0E);
        bus_write(10'h020, 8'h20);
        irq[6] = 1'b0;
        report_test("masking", errs_before);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        reset            = 1'b1;
        address          = '0;
        data             = '0;
        io_read_n        = 1'b1;
        io_write_n       = 1'b1;
        address_enable_n = 1'b1;
        iack_n           = 1'b1;
        irq              = '0;
        port_c           = '0;
        ps2_clock        = 1'b1;
        ps2_data         = 1'b1;
        repeat (5) @(negedge clock);
        reset = 1'b0;

        test_reset();
        test_registers();
        test_keyboard();
        test_vector_eoi();
        test_priority();
        test_masking();

        $display("%0d tests run, %0d failed, %0d check errors",
                 tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
src/periph_pkg.sv
src/io_bus_if.sv
src/isa_bus_interface.sv
src/ps2_receiver.sv
src/keyboard_port.sv
src/interrupt_controller.sv
src/periph_top.sv
testbench/tb_periph.sv

// File: Bender.yml
package:
  name: xt_periph

sources:
  - src/periph_pkg.sv
  - src/io_bus_if.sv
  - src/isa_bus_interface.sv
  - src/ps2_receiver.sv
  - src/keyboard_port.sv
  - src/interrupt_controller.sv
  - src/periph_top.sv
  - target: simulation
    files:
      - testbench/tb_periph.sv
